//--- Makefile
# Verilator build and run of the blimp core testbench

VERILATOR ?= verilator
TOP       ?= blimp_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
common/blimp_pkg.sv
fetch/blimp_fetch.sv
design/blimp_regfile.sv
design/blimp_decode.sv
design/blimp_execute.sv
design/blimp_result.sv
design/blimp_core.sv
sim/blimp_chk.sv
sim/blimp_check.sv
sim/blimp_tb.sv

//--- common/blimp_pkg.sv
/*
 * Blimp shared definitions
 * Decoded operations, fetch states, RV32 field positions and reset pc
 */

package blimp_pkg;

  // ------------------------------------------------
  // Decoded operation
  // ------------------------------------------------
  typedef enum logic [1:0] {
    op_addi,
    op_add,
    op_mul,
    op_other
  } blimp_opcode_e;

  // Fetch sequencing
  typedef enum logic {
    st_idle,
    st_run
  } blimp_fetch_state_e;

  // ------------------------------------------------
  // Instruction fields
  // ------------------------------------------------
  localparam int opcode_lo = 0;
  localparam int opcode_hi = 6;
  localparam int rd_lo     = 7;
  localparam int rd_hi     = 11;
  localparam int funct3_lo = 12;
  localparam int funct3_hi = 14;
  localparam int rs1_lo    = 15;
  localparam int rs1_hi    = 19;
  localparam int rs2_lo    = 20;
  localparam int rs2_hi    = 24;
  localparam int funct7_lo = 25;
  localparam int funct7_hi = 31;
  localparam int imm_lo    = 20;
  localparam int imm_hi    = 31;

  // Major opcodes for register-immediate and register-register ALU ops
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;

  // funct7 picks add or mul, funct3 is zero for all three
  localparam logic [6:0] funct7_add = 7'b0000000;
  localparam logic [6:0] funct7_mul = 7'b0000001;
  localparam logic [2:0] funct3_add = 3'b000;

  // First fetch address
  localparam logic [31:0] reset_pc = 32'h0000_0200;

endpackage

//--- design/blimp_core.sv
/*
 * Blimp core top level
 * Fetch, decode, execute and result around a 32-entry register file
 */

`timescale 1ns/100ps

module blimp_core import blimp_pkg::*; #(
  parameter int p_opaq_bits       = 8,
  parameter int p_max_outstanding = 2
) (
  input  logic                   clk,
  input  logic                   rst,
  output logic                   imem_req_val,
  input  logic                   imem_req_rdy,
  output logic [31:0]            imem_req_addr,
  output logic [p_opaq_bits-1:0] imem_req_opaque,
  input  logic                   imem_resp_val,
  output logic                   imem_resp_rdy,
  input  logic [31:0]            imem_resp_data,
  input  logic [p_opaq_bits-1:0] imem_resp_opaque,
  output logic                   trace_val,
  output logic [31:0]            trace_pc,
  output logic [4:0]             trace_waddr,
  output logic [31:0]            trace_wdata,
  output logic                   trace_wen
);

  // ------------------------------------------------
  // Stage links
  // ------------------------------------------------
  // Fetch to decode
  logic          f_val;
  logic          f_rdy;
  logic [31:0]   f_inst;
  logic [31:0]   f_pc;
  // Decode to execute
  logic          d_val;
  logic          d_rdy;
  blimp_opcode_e d_op;
  logic [31:0]   d_a;
  logic [31:0]   d_b;
  logic [4:0]    d_rd;
  logic          d_wen;
  logic [31:0]   d_pc;
  // Execute to result
  logic          x_val;
  logic          x_rdy;
  logic [31:0]   x_value;
  logic [4:0]    x_rd;
  logic          x_wen;
  logic [31:0]   x_pc;
  // Register file and scoreboard
  logic [4:0]    raddr0;
  logic [4:0]    raddr1;
  logic [31:0]   rdata0;
  logic [31:0]   rdata1;
  logic          wen;
  logic [4:0]    waddr;
  logic [31:0]   wdata;
  logic [4:0]    x_busy_rd;
  logic          x_busy_wen;
  logic [4:0]    r_busy_rd;
  logic          r_busy_wen;

  blimp_fetch #(
    .p_opaq_bits       (p_opaq_bits),
    .p_max_outstanding (p_max_outstanding)
  ) i_fetch (
    .clk, .rst,
    .imem_req_val, .imem_req_rdy, .imem_req_addr, .imem_req_opaque,
    .imem_resp_val, .imem_resp_rdy, .imem_resp_data, .imem_resp_opaque,
    .f_val, .f_rdy, .f_inst, .f_pc
  );

  blimp_decode i_decode (
    .clk, .rst,
    .f_val, .f_rdy, .f_inst, .f_pc,
    .raddr0, .raddr1, .rdata0, .rdata1,
    .d_val, .d_rdy, .d_op, .d_a, .d_b, .d_rd, .d_wen, .d_pc,
    .x_busy_rd, .x_busy_wen, .r_busy_rd, .r_busy_wen
  );

  blimp_regfile i_regfile (
    .clk, .rst,
    .raddr0, .rdata0, .raddr1, .rdata1,
    .wen, .waddr, .wdata
  );

  blimp_execute i_execute (
    .clk, .rst,
    .d_val, .d_rdy, .d_op, .d_a, .d_b, .d_rd, .d_wen, .d_pc,
    .x_val, .x_rdy, .x_value, .x_rd, .x_wen, .x_pc,
    .x_busy_rd, .x_busy_wen
  );

  blimp_result i_result (
    .clk, .rst,
    .x_val, .x_rdy, .x_value, .x_rd, .x_wen, .x_pc,
    .wen, .waddr, .wdata,
    .r_busy_rd, .r_busy_wen,
    .trace_val, .trace_pc, .trace_waddr, .trace_wdata, .trace_wen
  );

endmodule

//--- design/blimp_decode.sv
/*
 * Blimp decode stage
 * Classifies addi/add/mul, reads operands and stalls on pending writes
 */

`timescale 1ns/100ps

module blimp_decode import blimp_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          f_val,
  output logic          f_rdy,
  input  logic [31:0]   f_inst,
  input  logic [31:0]   f_pc,
  output logic [4:0]    raddr0,
  output logic [4:0]    raddr1,
  input  logic [31:0]   rdata0,
  input  logic [31:0]   rdata1,
  output logic          d_val,
  input  logic          d_rdy,
  output blimp_opcode_e d_op,
  output logic [31:0]   d_a,
  output logic [31:0]   d_b,
  output logic [4:0]    d_rd,
  output logic          d_wen,
  output logic [31:0]   d_pc,
  input  logic [4:0]    x_busy_rd,
  input  logic          x_busy_wen,
  input  logic [4:0]    r_busy_rd,
  input  logic          r_busy_wen
);

  blimp_opcode_e op;
  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  logic [4:0]    rd;
  logic [31:0]   imm;
  logic          use_rs1;
  logic          use_rs2;
  logic          hazard;

  // ------------------------------------------------
  // Field extraction
  // ------------------------------------------------
  assign opcode = f_inst[opcode_hi:opcode_lo];
  assign funct3 = f_inst[funct3_hi:funct3_lo];
  assign funct7 = f_inst[funct7_hi:funct7_lo];
  assign rd     = f_inst[rd_hi:rd_lo];
  assign raddr0 = f_inst[rs1_hi:rs1_lo];
  assign raddr1 = f_inst[rs2_hi:rs2_lo];
  // I-type immediate, sign extended
  assign imm    = {{20{f_inst[imm_hi]}}, f_inst[imm_hi:imm_lo]};

  always_comb begin
    op = op_other;
    if (opcode == opc_op_imm && funct3 == funct3_add)
      op = op_addi;
    else if (opcode == opc_op && funct3 == funct3_add && funct7 == funct7_add)
      op = op_add;
    else if (opcode == opc_op && funct3 == funct3_add && funct7 == funct7_mul)
      op = op_mul;
  end

  // ------------------------------------------------
  // Scoreboard
  // ------------------------------------------------
  // rs2 only matters for R-type; unknown ops read nothing
  assign use_rs1 = (op != op_other) && (raddr0 != 5'd0);
  assign use_rs2 = ((op == op_add) || (op == op_mul)) && (raddr1 != 5'd0);

  // Own output register counts too, it has not reached execute yet
  assign hazard =
    (use_rs1 && d_val && d_wen && (d_rd == raddr0)) ||
    (use_rs2 && d_val && d_wen && (d_rd == raddr1)) ||
    (use_rs1 && x_busy_wen && (x_busy_rd == raddr0)) ||
    (use_rs2 && x_busy_wen && (x_busy_rd == raddr1)) ||
    (use_rs1 && r_busy_wen && (r_busy_rd == raddr0)) ||
    (use_rs2 && r_busy_wen && (r_busy_rd == raddr1));

  assign f_rdy = (!d_val || d_rdy) && !hazard;

  always_ff @(posedge clk) begin
    if (rst)
      d_val <= 1'b0;
    else if (f_val && f_rdy)
      d_val <= 1'b1;
    else if (d_rdy)
      d_val <= 1'b0;
  end

  // Payload
  always_ff @(posedge clk) begin
    if (f_val && f_rdy) begin
      d_op  <= op;
      d_a   <= rdata0;
      d_b   <= (op == op_addi) ? imm : rdata1;
      d_rd  <= rd;
      d_wen <= (op != op_other) && (rd != 5'd0);
      d_pc  <= f_pc;
    end
  end

endmodule

//--- design/blimp_execute.sv
/*
 * Blimp execute stage
 * Registers the sum or low product word and forwards rd, wen and pc
 */

`timescale 1ns/100ps

module blimp_execute import blimp_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          d_val,
  output logic          d_rdy,
  input  blimp_opcode_e d_op,
  input  logic [31:0]   d_a,
  input  logic [31:0]   d_b,
  input  logic [4:0]    d_rd,
  input  logic          d_wen,
  input  logic [31:0]   d_pc,
  output logic          x_val,
  input  logic          x_rdy,
  output logic [31:0]   x_value,
  output logic [4:0]    x_rd,
  output logic          x_wen,
  output logic [31:0]   x_pc,
  output logic [4:0]    x_busy_rd,
  output logic          x_busy_wen
);

  logic [31:0] sum;
  logic [31:0] prod;
  logic [31:0] value;

  // Low word is the same for signed and unsigned operands
  assign sum  = d_a + d_b;
  assign prod = d_a * d_b;

  always_comb begin
    case (d_op)
      op_mul:  value = prod;
      default: value = sum;
    endcase
  end

  assign d_rdy = !x_val || x_rdy;

  always_ff @(posedge clk) begin
    if (rst)
      x_val <= 1'b0;
    else if (d_val && d_rdy)
      x_val <= 1'b1;
    else if (x_rdy)
      x_val <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (d_val && d_rdy) begin
      x_value <= value;
      x_rd    <= d_rd;
      x_wen   <= d_wen;
      x_pc    <= d_pc;
    end
  end

  // Pending write seen by decode
  assign x_busy_rd  = x_rd;
  assign x_busy_wen = x_val && x_wen;

endmodule

//--- design/blimp_regfile.sv
/*
 * Blimp register file
 * 32 x 32-bit, two async read ports with write bypass, x0 tied to zero
 */

`timescale 1ns/100ps

module blimp_regfile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  raddr0,
  output logic [31:0] rdata0,
  input  logic [4:0]  raddr1,
  output logic [31:0] rdata1,
  input  logic        wen,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (wen && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 first, then same-cycle write forwarding
  always_comb begin
    if (raddr0 == 5'd0)
      rdata0 = '0;
    else if (wen && (waddr == raddr0))
      rdata0 = wdata;
    else
      rdata0 = regs[raddr0];

    if (raddr1 == 5'd0)
      rdata1 = '0;
    else if (wen && (waddr == raddr1))
      rdata1 = wdata;
    else
      rdata1 = regs[raddr1];
  end

endmodule

//--- design/blimp_result.sv
/*
 * Blimp result stage
 * Retires one instruction per cycle into the register file and trace
 */

`timescale 1ns/100ps

module blimp_result (
  input  logic        clk,
  input  logic        rst,
  input  logic        x_val,
  output logic        x_rdy,
  input  logic [31:0] x_value,
  input  logic [4:0]  x_rd,
  input  logic        x_wen,
  input  logic [31:0] x_pc,
  output logic        wen,
  output logic [4:0]  waddr,
  output logic [31:0] wdata,
  output logic [4:0]  r_busy_rd,
  output logic        r_busy_wen,
  output logic        trace_val,
  output logic [31:0] trace_pc,
  output logic [4:0]  trace_waddr,
  output logic [31:0] trace_wdata,
  output logic        trace_wen
);

  logic        r_val;
  logic [31:0] r_value;
  logic [4:0]  r_rd;
  logic        r_wen;
  logic [31:0] r_pc;

  // Trace has no back-pressure
  assign x_rdy = 1'b1;

  always_ff @(posedge clk) begin
    if (rst)
      r_val <= 1'b0;
    else
      r_val <= x_val;
  end

  always_ff @(posedge clk) begin
    if (x_val) begin
      r_value <= x_value;
      r_rd    <= x_rd;
      r_wen   <= x_wen;
      r_pc    <= x_pc;
    end
  end

  // Register write in the retire cycle
  assign wen   = r_val && r_wen;
  assign waddr = r_rd;
  assign wdata = r_value;

  // Held rd keeps decode stalled until the write lands
  assign r_busy_rd  = r_rd;
  assign r_busy_wen = r_val && r_wen;

  assign trace_val   = r_val;
  assign trace_pc    = r_pc;
  assign trace_waddr = r_rd;
  assign trace_wdata = r_value;
  assign trace_wen   = r_wen;

endmodule

//--- fetch/blimp_fetch.sv
/*
 * Blimp fetch unit
 * Issues tagged in-order instruction requests and buffers the
 * responses in a small FIFO toward decode
 */

`timescale 1ns/100ps

module blimp_fetch import blimp_pkg::*; #(
  parameter int p_opaq_bits       = 8,
  parameter int p_max_outstanding = 2
) (
  input  logic                   clk,
  input  logic                   rst,
  output logic                   imem_req_val,
  input  logic                   imem_req_rdy,
  output logic [31:0]            imem_req_addr,
  output logic [p_opaq_bits-1:0] imem_req_opaque,
  input  logic                   imem_resp_val,
  output logic                   imem_resp_rdy,
  input  logic [31:0]            imem_resp_data,
  input  logic [p_opaq_bits-1:0] imem_resp_opaque,
  output logic                   f_val,
  input  logic                   f_rdy,
  output logic [31:0]            f_inst,
  output logic [31:0]            f_pc
);

  localparam int c_cnt_bits = $clog2(p_max_outstanding + 1);
  localparam int c_ptr_bits = (p_max_outstanding > 1) ? $clog2(p_max_outstanding) : 1;

  blimp_fetch_state_e     state;
  logic [31:0]            req_pc;
  logic [p_opaq_bits-1:0] req_tag;
  logic [c_cnt_bits-1:0]  outstanding;
  logic [c_cnt_bits-1:0]  count;
  logic [c_cnt_bits:0]    inflight;
  logic [31:0]            buf_mem [p_max_outstanding];
  logic [c_ptr_bits-1:0]  wptr;
  logic [c_ptr_bits-1:0]  rptr;
  logic [31:0]            out_pc;
  logic                   req_fire;
  logic                   resp_fire;
  logic                   pop;

  // Wrap for depths that are not a power of two
  function automatic logic [c_ptr_bits-1:0] next_ptr(input logic [c_ptr_bits-1:0] p);
    return (p == c_ptr_bits'(p_max_outstanding - 1)) ? '0 : p + 1'b1;
  endfunction

  assign req_fire  = imem_req_val && imem_req_rdy;
  assign resp_fire = imem_resp_val && imem_resp_rdy;
  assign pop       = f_val && f_rdy;

  // ------------------------------------------------
  // Request side
  // ------------------------------------------------
  // Requests in flight plus buffered responses never pass the limit
  assign inflight = (c_cnt_bits+1)'(outstanding) + (c_cnt_bits+1)'(count);

  assign imem_req_val    = (state == st_run) &&
                           (inflight < (c_cnt_bits+1)'(p_max_outstanding));
  assign imem_req_addr   = req_pc;
  assign imem_req_opaque = req_tag;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= st_idle;
      req_pc      <= reset_pc;
      req_tag     <= '0;
      outstanding <= '0;
    end else begin
      // One idle cycle out of reset, then fetch forever
      if (state == st_idle)
        state <= st_run;
      if (req_fire) begin
        req_pc  <= req_pc + 32'd4;
        req_tag <= req_tag + 1'b1;
      end
      outstanding <= outstanding + c_cnt_bits'(req_fire) - c_cnt_bits'(resp_fire);
    end
  end

  // ------------------------------------------------
  // Response buffer
  // ------------------------------------------------
  assign imem_resp_rdy = (count < c_cnt_bits'(p_max_outstanding));

  always_ff @(posedge clk) begin
    if (resp_fire)
      buf_mem[wptr] <= imem_resp_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wptr   <= '0;
      rptr   <= '0;
      count  <= '0;
      out_pc <= reset_pc;
    end else begin
      if (resp_fire)
        wptr <= next_ptr(wptr);
      // Output pc follows the pop count since responses stay in order
      if (pop) begin
        rptr   <= next_ptr(rptr);
        out_pc <= out_pc + 32'd4;
      end
      count <= count + c_cnt_bits'(resp_fire) - c_cnt_bits'(pop);
    end
  end

  assign f_val  = (count != '0);
  assign f_inst = buf_mem[rptr];
  assign f_pc   = out_pc;

endmodule

//--- sim/blimp_check.sv
/*
 * Blimp trace checker
 * Pops the expected retirements and compares every trace entry
 */

`timescale 1ns/100ps

module blimp_check (
  input  logic        clk,
  input  logic        rst,
  input  logic        imem_req_val,
  input  logic        trace_val,
  input  logic [31:0] trace_pc,
  input  logic [4:0]  trace_waddr,
  input  logic [31:0] trace_wdata,
  input  logic        trace_wen,
  output int          errors,
  output int          retired
);

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        wen;
  } trace_t;

  trace_t exp_q [$];
  logic   in_reset;

  initial begin
    errors  = 0;
    retired = 0;
  end

  // Filled by the testbench before the run
  task automatic add_expected(input logic [31:0] pc, input logic [4:0] waddr,
                              input logic [31:0] wdata, input logic wen);
    exp_q.push_back('{pc: pc, waddr: waddr, wdata: wdata, wen: wen});
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_drained();
    if (exp_q.size() != 0) begin
      $display("Run ended with %0d expected instructions never retired", exp_q.size());
      errors++;
    end
  endtask

  // Reset state as seen at the last rising edge
  always @(posedge clk)
    in_reset <= rst;

  // ------------------------------------------------
  // Trace compare, outputs stable at the falling edge
  // ------------------------------------------------
  always @(negedge clk) begin
    trace_t e;
    if (in_reset === 1'b1 && (trace_val !== 1'b0 || imem_req_val !== 1'b0)) begin
      $display("Trace entry or memory request seen while the core was in reset");
      errors++;
    end else if (trace_val === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Trace entry at pc %h retired with nothing left to expect", trace_pc);
        errors++;
      end else begin
        e = exp_q.pop_front();
        retired++;
        compare_field("trace_pc", trace_pc, e.pc);
        compare_field("trace_wen", 32'(trace_wen), 32'(e.wen));
        // Address and data only matter for a real write
        if (e.wen) begin
          compare_field("trace_waddr", 32'(trace_waddr), 32'(e.waddr));
          compare_field("trace_wdata", trace_wdata, e.wdata);
        end
      end
    end
  end

endmodule

//--- sim/blimp_chk.sv
/*
 * Blimp handshake assertions
 * Bound into the core to watch the instruction memory and trace ports
 */

`timescale 1ns/100ps

module blimp_chk #(
  parameter int p_opaq_bits = 8
) (
  input logic                   clk,
  input logic                   rst,
  input logic                   imem_req_val,
  input logic                   imem_req_rdy,
  input logic [31:0]            imem_req_addr,
  input logic [p_opaq_bits-1:0] imem_req_opaque,
  input logic                   imem_resp_val,
  input logic                   imem_resp_rdy,
  input logic [p_opaq_bits-1:0] imem_resp_opaque,
  input logic                   trace_val
);

  logic [p_opaq_bits-1:0] exp_tag;

  // Tag of the next response, one step per accepted response
  always_ff @(posedge clk) begin
    if (rst)
      exp_tag <= '0;
    else if (imem_resp_val && imem_resp_rdy)
      exp_tag <= exp_tag + 1'b1;
  end

  // Held request keeps its payload until accepted
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    imem_req_val && !imem_req_rdy |=>
      imem_req_val && $stable(imem_req_addr) && $stable(imem_req_opaque))
    else $error("request dropped or changed before it was accepted");

  a_resp_tag: assert property (@(posedge clk) disable iff (rst)
    imem_resp_val && imem_resp_rdy |-> imem_resp_opaque == exp_tag)
    else $error("response tag out of request order");

  // Cycle after a reset edge shows no retirement
  a_trace_reset: assert property (@(posedge clk) rst |=> !trace_val)
    else $error("trace entry while the core was in reset");

endmodule

//--- sim/blimp_tb.sv
/*
 * Blimp core testbench
 * Random addi/add/mul program, in-order memory with random delays
 */

`timescale 1ns/100ps

module blimp_tb import blimp_pkg::*; ();

  localparam int p_opaq_bits    = 6;
  localparam int n_inst         = 200;
  localparam int timeout_cycles = n_inst * 12 + 100;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   imem_req_val;
  logic                   imem_req_rdy;
  logic [31:0]            imem_req_addr;
  logic [p_opaq_bits-1:0] imem_req_opaque;
  logic                   imem_resp_val;
  logic                   imem_resp_rdy;
  logic [31:0]            imem_resp_data;
  logic [p_opaq_bits-1:0] imem_resp_opaque;
  logic                   trace_val;
  logic [31:0]            trace_pc;
  logic [4:0]             trace_waddr;
  logic [31:0]            trace_wdata;
  logic                   trace_wen;

  logic [31:0]            prog [n_inst];
  logic [31:0]            lfsr;
  logic [31:0]            pend_data [$];
  logic [p_opaq_bits-1:0] pend_tag [$];
  int                     req_wait;
  int                     resp_wait;
  logic                   req_fire;
  logic                   resp_fire;
  logic [31:0]            fire_addr;
  logic [p_opaq_bits-1:0] fire_tag;
  int                     errors;
  int                     retired;
  int                     cycles;
  logic                   timed_out;

  always #20 clk = ~clk;

  blimp_core #(
    .p_opaq_bits       (p_opaq_bits),
    .p_max_outstanding (2)
  ) i_dut (
    .clk, .rst,
    .imem_req_val, .imem_req_rdy, .imem_req_addr, .imem_req_opaque,
    .imem_resp_val, .imem_resp_rdy, .imem_resp_data, .imem_resp_opaque,
    .trace_val, .trace_pc, .trace_waddr, .trace_wdata, .trace_wen
  );

  blimp_check i_check (
    .clk, .rst, .imem_req_val,
    .trace_val, .trace_pc, .trace_waddr, .trace_wdata, .trace_wen,
    .errors, .retired
  );

  bind blimp_core blimp_chk #(.p_opaq_bits(p_opaq_bits)) i_chk (.*);

  // ------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------
  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] encode_i(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, funct3_add, rd, opc_op_imm};
  endfunction

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, funct3_add, rd, opc_op};
  endfunction

  function automatic logic in_program(input logic [31:0] addr);
    return (addr >= reset_pc) && (addr < reset_pc + 32'(4 * n_inst));
  endfunction

  // Expected value of one instruction from its source values
  function automatic logic [31:0] ref_result(input logic [31:0] inst, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [31:0] imm;
    longint      prod;
    imm  = {{20{inst[31]}}, inst[31:20]};
    prod = longint'($signed(a)) * longint'($signed(b));
    if (inst[6:0] == opc_op_imm)
      return a + imm;
    else if (inst[31:25] == funct7_mul)
      return prod[31:0];
    else
      return a + b;
  endfunction

  // Half addi, quarter add, quarter mul over x0..x7
  task automatic make_program();
    logic [1:0]  sel;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    for (int i = 0; i < n_inst; i++) begin
      sel = 2'(take_bits(2));
      rd  = 5'(take_bits(3));
      rs1 = 5'(take_bits(3));
      rs2 = 5'(take_bits(3));
      imm = 12'(take_bits(12));
      case (sel)
        2'd2:    prog[i] = encode_r(funct7_add, rd, rs1, rs2);
        2'd3:    prog[i] = encode_r(funct7_mul, rd, rs1, rs2);
        default: prog[i] = encode_i(rd, rs1, imm);
      endcase
    end
  endtask

  task automatic build_expected();
    logic [31:0] regs [32];
    logic [31:0] inst;
    logic [31:0] value;
    logic [4:0]  rd;
    for (int r = 0; r < 32; r++)
      regs[r] = '0;
    for (int i = 0; i < n_inst; i++) begin
      inst  = prog[i];
      rd    = inst[11:7];
      value = ref_result(inst, regs[inst[19:15]], regs[inst[24:20]]);
      if (rd != 5'd0)
        regs[rd] = value;
      i_check.add_expected(reset_pc + 32'(4 * i), rd, value, rd != 5'd0);
    end
  endtask

  // ------------------------------------------------
  // Instruction memory, in order, random delays
  // ------------------------------------------------
  always @(negedge clk) begin
    // Count down delays started on earlier cycles
    if (req_wait > 0)
      req_wait--;
    if (resp_wait > 0)
      resp_wait--;
    // Transfers completed at the last rising edge
    if (resp_fire) begin
      void'(pend_data.pop_front());
      void'(pend_tag.pop_front());
      imem_resp_val = 1'b0;
      resp_wait     = int'(take_bits(2));
    end
    if (req_fire) begin
      pend_data.push_back(prog[(fire_addr - reset_pc) >> 2]);
      pend_tag.push_back(fire_tag);
      req_wait = int'(take_bits(2));
    end
    // Nothing past the program end is ever accepted
    imem_req_rdy = (req_wait == 0) && in_program(imem_req_addr);
    if (!imem_resp_val && resp_wait == 0 && pend_data.size() != 0) begin
      imem_resp_val    = 1'b1;
      imem_resp_data   = pend_data[0];
      imem_resp_opaque = pend_tag[0];
    end
    // Transfers on the coming rising edge
    req_fire  = imem_req_val && imem_req_rdy;
    resp_fire = imem_resp_val && imem_resp_rdy;
    fire_addr = imem_req_addr;
    fire_tag  = imem_req_opaque;
  end

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial begin
    rst              = 1'b1;
    imem_req_rdy     = 1'b0;
    imem_resp_val    = 1'b0;
    imem_resp_data   = '0;
    imem_resp_opaque = '0;
    req_wait         = 0;
    resp_wait        = 0;
    req_fire         = 1'b0;
    resp_fire        = 1'b0;
    lfsr             = 32'h805b_0aab;
    make_program();
    build_expected();
    repeat (5) @(negedge clk);
    rst    = 1'b0;
    cycles = 0;
    while (retired < n_inst && cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    timed_out = (cycles >= timeout_cycles);
    if (timed_out) begin
      $display("Timeout after %0d cycles with %0d of %0d instructions retired",
               cycles, retired, n_inst);
    end else begin
      // A few idle cycles to catch stray retirements
      repeat (4) @(posedge clk);
    end
    i_check.check_drained();
    $display("Summary: %0d errors, %0d of %0d instructions retired", errors, retired, n_inst);
    if (!timed_out && errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule
